/* Bender.yml */
package:
  name: banked_mem_xbar

sources:
  - files:
      - xbar_pkg.sv
      - xbar_arbiter.sv
      - xbar_req_route.sv
      - xbar_bank_mem.sv
      - xbar_rsp_route.sv
      - banked_mem_xbar.sv
  - target: test
    files:
      - banked_mem_xbar_assertions.sv
      - tb_banked_mem_xbar.sv

/* banked_mem_xbar.sv */
/*
  banked memory crossbar
  NUM_PORTS requesters share NUM_BANKS memory banks, round-robin per bank,
  reads return one cycle after acceptance
*/
module banked_mem_xbar (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [xbar_pkg::NUM_PORTS-1:0]                        valid_i,
  input  xbar_pkg::xbar_req_t [xbar_pkg::NUM_PORTS-1:0]         req_i,
  output logic [xbar_pkg::NUM_PORTS-1:0]                        yumi_o,
  output logic [xbar_pkg::NUM_PORTS-1:0]                        rvalid_o,
  output logic [xbar_pkg::NUM_PORTS-1:0][xbar_pkg::DATA_W-1:0] rdata_o
);

  xbar_pkg::xbar_addr_u [xbar_pkg::NUM_PORTS-1:0]           req_addr;
  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::NUM_PORTS-1:0] grant;
  xbar_pkg::bank_req_t [xbar_pkg::NUM_BANKS-1:0]           bank_req;
  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::DATA_W-1:0]    bank_rdata;

  // arbiter only needs the addresses
  for (genvar p = 0; p < xbar_pkg::NUM_PORTS; p++)
  begin : g_addr
    assign req_addr[p] = req_i[p].addr;
  end

  xbar_arbiter xbar_arbiter_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .req_addr_i (req_addr),
    .grant_o    (grant),
    .yumi_o     (yumi_o)
  );

  xbar_req_route xbar_req_route_i (
    .grant_i    (grant),
    .req_i      (req_i),
    .bank_req_o (bank_req)
  );

  xbar_bank_mem xbar_bank_mem_i (
    .clk_i        (clk_i),
    .bank_req_i   (bank_req),
    .bank_rdata_o (bank_rdata)
  );

  xbar_rsp_route xbar_rsp_route_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .grant_i      (grant),
    .bank_req_i   (bank_req),
    .bank_rdata_i (bank_rdata),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o)
  );

endmodule

/* banked_mem_xbar_assertions.sv */
/*
  crossbar checker bound into the top level
  keeps a shadow copy of the banks from accepted writes and checks
  reset, handshake, read data, response timing and fairness
*/
module banked_mem_xbar_assertions (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [xbar_pkg::NUM_PORTS-1:0]                        valid_i,
  input  xbar_pkg::xbar_req_t [xbar_pkg::NUM_PORTS-1:0]         req_i,
  input  logic [xbar_pkg::NUM_PORTS-1:0]                        yumi_i,
  input  logic [xbar_pkg::NUM_PORTS-1:0]                        rvalid_i,
  input  logic [xbar_pkg::NUM_PORTS-1:0][xbar_pkg::DATA_W-1:0] rdata_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int err_cnt = 0;

  // whole address space indexed by the flat word address
  logic [xbar_pkg::DATA_W-1:0] shadow [xbar_pkg::NUM_BANKS * xbar_pkg::BANK_WORDS];
  logic [xbar_pkg::NUM_PORTS-1:0][xbar_pkg::DATA_W-1:0]    exp_q;
  logic [xbar_pkg::NUM_PORTS-1:0]                          acc_rd;
  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::NUM_PORTS-1:0] bank_vec;
  int                                                      wait_q [xbar_pkg::NUM_PORTS];

  // valid requests per bank from the high address bits
  always_comb
  begin
    for (int b = 0; b < xbar_pkg::NUM_BANKS; b++)
    begin
      for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
      begin
        bank_vec[b][p] = valid_i[p] &&
          (req_i[p].addr.flat[xbar_pkg::ADDR_W-1 -: xbar_pkg::BANK_W] == b);
      end
    end
  end

  // shadow update and expected read word at acceptance
  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
      begin
        if (valid_i[p] && yumi_i[p])
        begin
          if (req_i[p].we)
          begin
            for (int i = 0; i < xbar_pkg::MASK_W; i++)
            begin
              if (req_i[p].mask[i])
                shadow[req_i[p].addr.flat][8*i +: 8] <= req_i[p].wdata[8*i +: 8];
            end
          end
          else
          begin
            exp_q[p] <= shadow[req_i[p].addr.flat];
          end
        end
      end
    end
  end

  // consecutive cycles a port has waited
  always @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
        wait_q[p] <= 0;
    end
    else
    begin
      for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
        wait_q[p] <= (valid_i[p] && !yumi_i[p]) ? wait_q[p] + 1 : 0;
    end
  end

  ap_reset_quiet: assert property (@(posedge clk_i)
    (!rst_n_i || !$past(rst_n_i)) |-> (rvalid_i == '0))
  else
  begin
    $error("ERROR rvalid_o = %h during or right after reset", $sampled(rvalid_i));
    err_cnt = err_cnt + 1;
  end

  for (genvar p = 0; p < xbar_pkg::NUM_PORTS; p++)
  begin : g_port
    assign acc_rd[p] = valid_i[p] & yumi_i[p] & ~req_i[p].we;

    ap_yumi_valid: assert property (@(posedge clk_i) !valid_i[p] |-> !yumi_i[p])
    else
    begin
      $error("yumi_o[%0d] was high while its valid_i was low", p);
      err_cnt = err_cnt + 1;
    end

    ap_rd_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      acc_rd[p] |=> rvalid_i[p])
    else
    begin
      $error("rvalid_o[%0d] missing one cycle after an accepted read", p);
      err_cnt = err_cnt + 1;
    end

    ap_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !acc_rd[p] |=> !rvalid_i[p])
    else
    begin
      $error("rvalid_o[%0d] was high without an accepted read", p);
      err_cnt = err_cnt + 1;
    end

    ap_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_i[p] |-> (rdata_i[p] === exp_q[p]))
    else
    begin
      $error("ERROR rdata_o[%0d] = %h expected %h", p, $sampled(rdata_i[p]),
             $sampled(exp_q[p]));
      err_cnt = err_cnt + 1;
    end

    // round robin bounds the wait to NUM_PORTS-1 lost cycles
    ap_wait_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (valid_i[p] && !yumi_i[p]) |-> (wait_q[p] < xbar_pkg::NUM_PORTS - 1))
    else
    begin
      $error("port %0d waited too long for acceptance", p);
      err_cnt = err_cnt + 1;
    end

    ap_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (valid_i[p] && !yumi_i[p]) |=> (valid_i[p] && $stable(req_i[p])))
    else
    begin
      $error("port %0d changed its request before acceptance", p);
      err_cnt = err_cnt + 1;
    end
  end

  for (genvar b = 0; b < xbar_pkg::NUM_BANKS; b++)
  begin : g_bank
    ap_one_winner: assert property (@(posedge clk_i) $onehot0(yumi_i & bank_vec[b]))
    else
    begin
      $error("ERROR yumi_o = %h grants several ports on bank %0d", $sampled(yumi_i), b);
      err_cnt = err_cnt + 1;
    end

    ap_bank_served: assert property (@(posedge clk_i)
      (|bank_vec[b]) |-> (|(yumi_i & bank_vec[b])))
    else
    begin
      $error("bank %0d had requests but accepted none", b);
      err_cnt = err_cnt + 1;
    end
  end

endmodule

/* sources.f */
xbar_pkg.sv
xbar_arbiter.sv
xbar_req_route.sv
xbar_bank_mem.sv
xbar_rsp_route.sv
banked_mem_xbar.sv
banked_mem_xbar_assertions.sv
tb_banked_mem_xbar.sv

/* tb_banked_mem_xbar.sv */
/*
  testbench for the banked memory crossbar
  drives held request streams on every port and reports each test
*/
module tb_banked_mem_xbar;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum int {mode_fill, mode_write, mode_read, mode_mix, mode_same} mode_e;

  logic                                                  clk = 1'b0;
  logic                                                  rst_n;
  logic [xbar_pkg::NUM_PORTS-1:0]                        valid;
  xbar_pkg::xbar_req_t [xbar_pkg::NUM_PORTS-1:0]         req;
  logic [xbar_pkg::NUM_PORTS-1:0]                        yumi;
  logic [xbar_pkg::NUM_PORTS-1:0]                        rvalid;
  logic [xbar_pkg::NUM_PORTS-1:0][xbar_pkg::DATA_W-1:0] rdata;
  logic [xbar_pkg::NUM_PORTS-1:0]                        accepted_q;

  integer seed     = 63602;
  int     passed   = 0;
  int     failed   = 0;
  int     fill_ops = xbar_pkg::BANK_WORDS;
  int     wr_ops   = 48;
  int     rd_ops   = 48;
  int     mix_ops  = 64;
  int     same_ops = 24;

  always #10 clk = ~clk;

  banked_mem_xbar banked_mem_xbar_i (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .valid_i  (valid),
    .req_i    (req),
    .yumi_o   (yumi),
    .rvalid_o (rvalid),
    .rdata_o  (rdata)
  );

  bind banked_mem_xbar banked_mem_xbar_assertions banked_mem_xbar_assertions_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .yumi_i   (yumi_o),
    .rvalid_i (rvalid_o),
    .rdata_i  (rdata_o)
  );

  // acceptance as seen at the rising edge
  always @(posedge clk)
    accepted_q <= valid & yumi;

  function automatic xbar_pkg::xbar_req_t make_req(input mode_e mode, input int port,
                                                   input int idx);
    xbar_pkg::xbar_req_t r;
    int bank;
    int row;
    bank    = $random(seed) & (xbar_pkg::NUM_BANKS - 1);
    // few rows so reads often hit earlier writes
    row     = $random(seed) & 15;
    r.we    = 1'($random(seed));
    r.wdata = $random(seed);
    r.mask  = xbar_pkg::MASK_W'($random(seed));
    case (mode)
      mode_fill:
      begin
        bank   = port;
        row    = idx;
        r.we   = 1'b1;
        r.mask = '1;
      end
      mode_write: r.we = 1'b1;
      mode_read:  r.we = 1'b0;
      mode_same:  bank = 0;
      default:    ;
    endcase
    r.addr.flat = xbar_pkg::ADDR_W'(bank * xbar_pkg::BANK_WORDS + row);
    return r;
  endfunction

  // every port issues ops requests, each held until accepted
  task automatic run_phase(input mode_e mode, input int ops);
    int issued [xbar_pkg::NUM_PORTS];
    bit busy;
    bit go;
    for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
      issued[p] = 0;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = 1'b0;
      for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
      begin
        if (accepted_q[p])
          valid[p] = 1'b0;
        // random modes leave some idle cycles
        go = (mode == mode_fill) || (mode == mode_same) || (($random(seed) & 3) != 0);
        if (!valid[p] && issued[p] < ops && go)
        begin
          req[p]    = make_req(mode, p, issued[p]);
          valid[p]  = 1'b1;
          issued[p] = issued[p] + 1;
        end
        if (valid[p] || issued[p] < ops)
          busy = 1'b1;
      end
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = banked_mem_xbar_i.banked_mem_xbar_assertions_i.err_cnt - errs_before;
    if (errs == 0)
    begin
      passed = passed + 1;
      $display("test %-14s ok", name);
    end
    else
    begin
      failed = failed + 1;
      $display("test %-14s %0d assertion failures", name, errs);
    end
  endtask

  task automatic run_test(input string name, input mode_e mode, input int ops);
    int errs_before;
    errs_before = banked_mem_xbar_i.banked_mem_xbar_assertions_i.err_cnt;
    run_phase(mode, ops);
    report_test(name, errs_before);
  endtask

  initial
  begin
    rst_n = 1'b0;
    valid = '0;
    req   = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    report_test("reset", 0);
    // each port fills its own bank so all four go through each cycle
    run_test("fill", mode_fill, fill_ops);
    run_test("masked_writes", mode_write, wr_ops);
    run_test("reads", mode_read, rd_ops);
    run_test("mixed", mode_mix, mix_ops);
    run_test("same_bank", mode_same, same_ops);
    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // worst case NUM_PORTS cycles per request plus reset and drain
  initial
  begin : watchdog
    int budget;
    budget = 6 + 5 * 3 + (fill_ops + wr_ops + rd_ops + mix_ops + same_ops) *
             xbar_pkg::NUM_PORTS;
    #(budget * 20 * 3);
    $display("timeout: the tests did not finish within %0d ns", budget * 20 * 3);
    $display("Checks failed");
    $finish;
  end

endmodule

/* xbar_arbiter.sv */
/*
  crossbar arbiter
  one round-robin arbiter per bank, grants a single port per cycle
  and acknowledges the winners with yumi in the same cycle
*/
module xbar_arbiter (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  logic [xbar_pkg::NUM_PORTS-1:0]                           valid_i,
  input  xbar_pkg::xbar_addr_u [xbar_pkg::NUM_PORTS-1:0]           req_addr_i,
  output logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::NUM_PORTS-1:0] grant_o,
  output logic [xbar_pkg::NUM_PORTS-1:0]                           yumi_o
);

  // requests sorted per bank
  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::NUM_PORTS-1:0] bank_reqs;

  // first port each bank looks at
  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::PORT_W-1:0] ptr_q;
  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::PORT_W-1:0] winner;
  logic [xbar_pkg::NUM_BANKS-1:0]                       bank_busy;

  // decode the bank field of each valid request
  always_comb
  begin
    for (int b = 0; b < xbar_pkg::NUM_BANKS; b++)
    begin
      for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
      begin
        bank_reqs[b][p] = valid_i[p] &&
                          (req_addr_i[p].split.bank == xbar_pkg::BANK_W'(b));
      end
    end
  end

  // first requester at or after the pointer wins
  always_comb
  begin
    int idx;
    grant_o   = '0;
    winner    = '0;
    bank_busy = '0;
    for (int b = 0; b < xbar_pkg::NUM_BANKS; b++)
    begin
      for (int k = 0; k < xbar_pkg::NUM_PORTS; k++)
      begin
        idx = (int'(ptr_q[b]) + k) % xbar_pkg::NUM_PORTS;
        if (!bank_busy[b] && bank_reqs[b][idx])
        begin
          bank_busy[b]      = 1'b1;
          winner[b]         = xbar_pkg::PORT_W'(idx);
          grant_o[b][idx]   = 1'b1;
        end
      end
    end
  end

  // a port is accepted when any bank names it
  always_comb
  begin
    yumi_o = '0;
    for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
    begin
      for (int b = 0; b < xbar_pkg::NUM_BANKS; b++)
      begin
        yumi_o[p] = yumi_o[p] | grant_o[b][p];
      end
      yumi_o[p] = yumi_o[p] & valid_i[p];
    end
  end

  // pointer moves just past the winner and idle banks keep theirs
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ptr_q <= '0;
    end
    else
    begin
      for (int b = 0; b < xbar_pkg::NUM_BANKS; b++)
      begin
        if (bank_busy[b])
        begin
          if (int'(winner[b]) == xbar_pkg::NUM_PORTS - 1)
            ptr_q[b] <= '0;
          else
            ptr_q[b] <= winner[b] + 1'b1;
        end
      end
    end
  end

endmodule

/* xbar_bank_mem.sv */
/*
  bank storage
  every bank is a synchronous single-port memory with byte-masked
  writes and a registered read output
*/
module xbar_bank_mem (
  input  logic                                                    clk_i,
  input  xbar_pkg::bank_req_t [xbar_pkg::NUM_BANKS-1:0]           bank_req_i,
  output logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::DATA_W-1:0]    bank_rdata_o
);

  logic [xbar_pkg::DATA_W-1:0] mem [xbar_pkg::NUM_BANKS][xbar_pkg::BANK_WORDS];

  // read data register per bank
  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i)
  begin
    for (int b = 0; b < xbar_pkg::NUM_BANKS; b++)
    begin
      if (bank_req_i[b].en)
      begin
        if (bank_req_i[b].we)
        begin
          // only bytes with their mask bit set
          for (int i = 0; i < xbar_pkg::MASK_W; i++)
          begin
            if (bank_req_i[b].mask[i])
            begin
              mem[b][bank_req_i[b].row][8*i +: 8] <= bank_req_i[b].wdata[8*i +: 8];
            end
          end
        end
        else
        begin
          rdata_q[b] <= mem[b][bank_req_i[b].row];
        end
      end
    end
  end

  assign bank_rdata_o = rdata_q;

endmodule

/* xbar_pkg.sv */
/*
  banked memory crossbar package
  sizes of ports, banks and rows, the split address view
  and the request records seen at the ports and the banks
*/
package xbar_pkg;

  // requesters and banks
  localparam int NUM_PORTS  = 4;
  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 64;

  // data word and byte enables
  localparam int DATA_W = 32;
  localparam int MASK_W = DATA_W / 8;

  // index widths
  localparam int PORT_W = $clog2(NUM_PORTS);
  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ROW_W  = $clog2(BANK_WORDS);
  localparam int ADDR_W = BANK_W + ROW_W;

  // bank in the high bits and row in the low bits
  typedef struct packed {
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
  } xbar_addr_split_t;

  // word address read flat at the ports or split in the crossbar
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    xbar_addr_split_t  split;
  } xbar_addr_u;

  // request from one port without its valid
  typedef struct packed {
    logic              we;
    xbar_addr_u        addr;
    logic [DATA_W-1:0] wdata;
    // 1 = write this byte
    logic [MASK_W-1:0] mask;
  } xbar_req_t;

  // access presented to one bank
  typedef struct packed {
    logic              en;
    logic              we;
    logic [ROW_W-1:0]  row;
    logic [DATA_W-1:0] wdata;
    logic [MASK_W-1:0] mask;
  } bank_req_t;

endpackage

/* xbar_req_route.sv */
/*
  request router
  steers the granted port request of each bank onto that bank's
  request bus with one-hot AND-OR selection
*/
module xbar_req_route (
  input  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::NUM_PORTS-1:0] grant_i,
  input  xbar_pkg::xbar_req_t [xbar_pkg::NUM_PORTS-1:0]           req_i,
  output xbar_pkg::bank_req_t [xbar_pkg::NUM_BANKS-1:0]           bank_req_o
);

  always_comb
  begin
    logic                        sel;
    logic                        we;
    logic [xbar_pkg::ROW_W-1:0]  row;
    logic [xbar_pkg::DATA_W-1:0] wdata;
    logic [xbar_pkg::MASK_W-1:0] mask;
    for (int b = 0; b < xbar_pkg::NUM_BANKS; b++)
    begin
      we    = 1'b0;
      row   = '0;
      wdata = '0;
      mask  = '0;
      for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
      begin
        sel   = grant_i[b][p];
        we    = we | (sel & req_i[p].we);
        row   = row | ({xbar_pkg::ROW_W{sel}} & req_i[p].addr.split.row);
        wdata = wdata | ({xbar_pkg::DATA_W{sel}} & req_i[p].wdata);
        mask  = mask | ({xbar_pkg::MASK_W{sel}} & req_i[p].mask);
      end
      // bank works only when some port owns it
      bank_req_o[b].en    = |grant_i[b];
      bank_req_o[b].we    = we;
      bank_req_o[b].row   = row;
      bank_req_o[b].wdata = wdata;
      bank_req_o[b].mask  = mask;
    end
  end

endmodule

/* xbar_rsp_route.sv */
/*
  response router
  remembers which port each bank served and whether it was a read,
  then hands the bank read data back to that port
*/
module xbar_rsp_route (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::NUM_PORTS-1:0] grant_i,
  input  xbar_pkg::bank_req_t [xbar_pkg::NUM_BANKS-1:0]           bank_req_i,
  input  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::DATA_W-1:0]    bank_rdata_i,
  output logic [xbar_pkg::NUM_PORTS-1:0]                           rvalid_o,
  output logic [xbar_pkg::NUM_PORTS-1:0][xbar_pkg::DATA_W-1:0]    rdata_o
);

  // aligned with the memory output register
  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::NUM_PORTS-1:0] grant_q;
  logic [xbar_pkg::NUM_BANKS-1:0]                          rd_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      grant_q <= '0;
      rd_q    <= '0;
    end
    else
    begin
      grant_q <= grant_i;
      for (int b = 0; b < xbar_pkg::NUM_BANKS; b++)
      begin
        rd_q[b] <= bank_req_i[b].en & ~bank_req_i[b].we;
      end
    end
  end

  // each port picks the bank that served it
  always_comb
  begin
    rvalid_o = '0;
    rdata_o  = '0;
    for (int p = 0; p < xbar_pkg::NUM_PORTS; p++)
    begin
      for (int b = 0; b < xbar_pkg::NUM_BANKS; b++)
      begin
        rvalid_o[p] = rvalid_o[p] | (grant_q[b][p] & rd_q[b]);
        rdata_o[p]  = rdata_o[p] |
                      ({xbar_pkg::DATA_W{grant_q[b][p]}} & bank_rdata_i[b]);
      end
    end
  end

endmodule
